/* core_pkg.sv */
package core_pkg;

  // datapath widths
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;   // instruction or data address
  typedef logic [XLEN-1:0] word_t;   // instruction or data word

  // trap bus with one bit per exception cause
  localparam int TRAP_LEN = 16;

  typedef logic [TRAP_LEN-1:0] trap_t;

  localparam int TRAP_INST_ADDR_MISALIGNED = 0;
  localparam int TRAP_INST_ACCESS_FAULT    = 1;
  localparam int TRAP_INST_PAGE_FAULT      = 12;  // never raised without an mmu

  // fetch constants
  localparam addr_t RESET_PC  = 32'h0000_0000;
  localparam addr_t MEM_BYTES = 32'd4096;       // fetch at or above this faults
  localparam word_t NOP_INST  = 32'h0000_0013;  // addi x0, x0, 0

  // branch predictor sizing
  // index is pc[7:2], tag is pc[31:8]
  localparam int BPU_IDX_W   = 6;
  localparam int BPU_TAG_W   = 24;
  localparam int BPU_ENTRIES = 1 << BPU_IDX_W;

  typedef logic [1:0] bpu_ctr_t;  // 2-bit saturating counter

  localparam bpu_ctr_t CTR_INIT = 2'b01;  // weakly not-taken

  // memory port owner
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_LS
  } arb_state_t;

endpackage

/* pc_reg.sv */
`timescale 1ns/1ps

module pc_reg (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            advance_i,         // ifu accepted the current fetch
  input  logic            ex_redirect_i,
  input  core_pkg::addr_t ex_redirect_pc_i,
  input  logic            pred_taken_i,
  input  core_pkg::addr_t pred_target_i,
  output core_pkg::addr_t pc_o
);

  core_pkg::addr_t pc_q;
  core_pkg::addr_t pc_seq;
  core_pkg::addr_t pc_next;
  logic            pc_load;

  assign pc_seq = pc_q + core_pkg::addr_t'(4);

  // redirect first, then prediction, then sequential
  always_comb begin
    if (ex_redirect_i) begin
      pc_next = ex_redirect_pc_i;
    end else if (pred_taken_i) begin
      pc_next = pred_target_i;
    end else begin
      pc_next = pc_seq;
    end
  end

  // pc only moves on a redirect or an accepted fetch
  assign pc_load = ex_redirect_i || advance_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= core_pkg::RESET_PC;
    end else if (pc_load) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

/* bpu.sv */
`timescale 1ns/1ps

module bpu (
  input  logic            clk,
  input  logic            reset_i,
  input  core_pkg::addr_t if_pc_i,
  // training from execute
  input  logic            ex_branch_valid_i,
  input  logic            ex_branch_taken_i,
  input  core_pkg::addr_t ex_pc_i,
  input  core_pkg::addr_t ex_target_i,
  output logic            pred_taken_o,
  output core_pkg::addr_t pred_target_o
);

  localparam int IDX_LO = 2;
  localparam int IDX_HI = IDX_LO + core_pkg::BPU_IDX_W - 1;
  localparam int TAG_LO = IDX_HI + 1;

  // bimodal counter table
  core_pkg::bpu_ctr_t ctr_tbl [core_pkg::BPU_ENTRIES];

  // branch target buffer
  logic                          btb_valid  [core_pkg::BPU_ENTRIES];
  logic [core_pkg::BPU_TAG_W-1:0] btb_tag    [core_pkg::BPU_ENTRIES];
  core_pkg::addr_t               btb_target [core_pkg::BPU_ENTRIES];

  logic [core_pkg::BPU_IDX_W-1:0] if_idx;
  logic [core_pkg::BPU_TAG_W-1:0] if_tag;
  logic [core_pkg::BPU_IDX_W-1:0] ex_idx;
  logic [core_pkg::BPU_TAG_W-1:0] ex_tag;
  logic                          btb_hit;
  core_pkg::bpu_ctr_t            ex_ctr;
  core_pkg::bpu_ctr_t            ex_ctr_next;

  assign if_idx = if_pc_i[IDX_HI:IDX_LO];
  assign if_tag = if_pc_i[core_pkg::XLEN-1:TAG_LO];
  assign ex_idx = ex_pc_i[IDX_HI:IDX_LO];
  assign ex_tag = ex_pc_i[core_pkg::XLEN-1:TAG_LO];

  // lookup on the current fetch pc
  assign btb_hit       = btb_valid[if_idx] && (btb_tag[if_idx] == if_tag);
  assign pred_taken_o  = btb_hit && ctr_tbl[if_idx][1];  // upper bit means taken
  assign pred_target_o = btb_target[if_idx];

  // saturating update of the trained counter
  assign ex_ctr = ctr_tbl[ex_idx];

  always_comb begin
    ex_ctr_next = ex_ctr;
    if (ex_branch_taken_i) begin
      if (ex_ctr != 2'b11) begin
        ex_ctr_next = ex_ctr + 2'b01;
      end
    end else begin
      if (ex_ctr != 2'b00) begin
        ex_ctr_next = ex_ctr - 2'b01;
      end
    end
  end

  // counters and valid bits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < core_pkg::BPU_ENTRIES; i++) begin
        ctr_tbl[i]   <= core_pkg::CTR_INIT;
        btb_valid[i] <= 1'b0;
      end
    end else if (ex_branch_valid_i) begin
      ctr_tbl[ex_idx] <= ex_ctr_next;
      if (ex_branch_taken_i) begin
        btb_valid[ex_idx] <= 1'b1;
      end
    end
  end

  // tag and target payload written only by taken branches
  always_ff @(posedge clk) begin
    if (ex_branch_valid_i && ex_branch_taken_i) begin
      btb_tag[ex_idx]    <= ex_tag;
      btb_target[ex_idx] <= ex_target_i;
    end
  end

endmodule

/* ifu.sv */
`timescale 1ns/1ps

module ifu (
  input  logic            clk,
  input  logic            reset_i,
  input  core_pkg::addr_t pc_i,            // from pc_reg
  input  logic            pred_taken_i,    // from bpu, for pc_i
  // memory side through the arbiter
  input  logic            fetch_ready_i,
  input  core_pkg::word_t fetch_rdata_i,
  output logic            fetch_req_o,
  output core_pkg::addr_t fetch_addr_o,
  input  logic            ls_busy_i,
  input  logic            ex_redirect_i,
  input  logic            id_stall_i,
  output logic            advance_o,       // to pc_reg
  output logic            if_stall_o,
  // IF/ID register
  output logic            inst_valid_o,
  output core_pkg::addr_t inst_addr_o,
  output core_pkg::word_t inst_data_o,
  output core_pkg::trap_t trap_o,
  output logic            pred_taken_o
);

  core_pkg::trap_t trap_now;
  logic            trap_any;
  logic            start_q;      // pc settled and fetch not yet launched
  logic            fetch_req_q;
  logic            drop_q;       // pending word is stale
  core_pkg::addr_t fetch_addr_q;
  logic            buf_free;
  logic            launch;
  logic            issue;
  logic            take_mem;
  logic            take_trap;

  logic            out_valid_q;
  core_pkg::addr_t out_addr_q;
  core_pkg::word_t out_data_q;
  core_pkg::trap_t out_trap_q;
  logic            out_pred_q;

  // trap check on the current pc
  always_comb begin
    trap_now = '0;
    trap_now[core_pkg::TRAP_INST_ADDR_MISALIGNED] = |pc_i[1:0];
    trap_now[core_pkg::TRAP_INST_ACCESS_FAULT]    = (pc_i >= core_pkg::MEM_BYTES);
    trap_now[core_pkg::TRAP_INST_PAGE_FAULT]      = 1'b0;
  end

  assign trap_any = |trap_now;

  assign buf_free  = !out_valid_q || !id_stall_i;  // empty or consumed now
  assign launch    = start_q && !fetch_req_q && buf_free && !ex_redirect_i;
  assign issue     = launch && !trap_any;
  assign take_trap = launch && trap_any;           // no memory access
  assign take_mem  = fetch_req_q && fetch_ready_i && !drop_q && !ex_redirect_i;
  assign advance_o = take_mem || take_trap;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      start_q     <= 1'b1;  // reset pc is already in place
      fetch_req_q <= 1'b0;
      drop_q      <= 1'b0;
      out_valid_q <= 1'b0;
      out_pred_q  <= 1'b0;
    end else begin
      if (ex_redirect_i || advance_o) begin
        start_q <= 1'b1;
      end else if (issue) begin
        start_q <= 1'b0;
      end

      // request level held until the ready pulse
      if (issue) begin
        fetch_req_q <= 1'b1;
      end else if (fetch_ready_i) begin
        fetch_req_q <= 1'b0;
      end

      // in-flight fetch finishes on the port but is thrown away
      if (fetch_req_q && fetch_ready_i) begin
        drop_q <= 1'b0;
      end else if (fetch_req_q && ex_redirect_i) begin
        drop_q <= 1'b1;
      end

      if (advance_o) begin
        out_valid_q <= 1'b1;
        out_pred_q  <= pred_taken_i;
      end else if (!id_stall_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (issue) begin
      fetch_addr_q <= pc_i;
    end
    if (take_trap) begin
      out_addr_q <= pc_i;
      out_data_q <= core_pkg::NOP_INST;
      out_trap_q <= trap_now;
    end else if (take_mem) begin
      out_addr_q <= fetch_addr_q;
      out_data_q <= fetch_rdata_i;
      out_trap_q <= '0;
    end
  end

  assign fetch_req_o  = fetch_req_q;
  assign fetch_addr_o = fetch_addr_q;

  // load/store owns the port, so fetch waiting is not a stall
  assign if_stall_o = fetch_req_q && !fetch_ready_i && !ls_busy_i;

  assign inst_valid_o = out_valid_q;
  assign inst_addr_o  = out_addr_q;
  assign inst_data_o  = out_data_q;
  assign trap_o       = out_trap_q;
  assign pred_taken_o = out_pred_q;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic            clk,
  input  logic            reset_i,
  // fetch side
  input  logic            fetch_req_i,
  input  core_pkg::addr_t fetch_addr_i,
  output logic            fetch_ready_o,
  output core_pkg::word_t fetch_rdata_o,
  // load/store side
  input  logic            ls_req_i,
  input  logic            ls_we_i,
  input  core_pkg::addr_t ls_addr_i,
  input  core_pkg::word_t ls_wdata_i,
  output logic            ls_ready_o,
  output core_pkg::word_t ls_rdata_o,
  output logic            ls_busy_o,
  // external memory port
  output logic            mem_req_o,
  output logic            mem_we_o,
  output core_pkg::addr_t mem_addr_o,
  output core_pkg::word_t mem_wdata_o,
  input  logic            mem_ready_i,
  input  core_pkg::word_t mem_rdata_i
);

  core_pkg::arb_state_t state_q;
  core_pkg::arb_state_t state_next;
  logic                 own_fetch;
  logic                 own_ls;

  assign own_fetch = (state_q == core_pkg::ARB_FETCH);
  assign own_ls    = (state_q == core_pkg::ARB_LS);

  always_comb begin
    state_next = state_q;
    case (state_q)
      core_pkg::ARB_IDLE: begin
        if (ls_req_i) begin
          state_next = core_pkg::ARB_LS;  // load/store wins
        end else if (fetch_req_i) begin
          state_next = core_pkg::ARB_FETCH;
        end
      end
      core_pkg::ARB_FETCH, core_pkg::ARB_LS: begin
        if (mem_ready_i) begin
          state_next = core_pkg::ARB_IDLE;
        end
      end
      default: state_next = core_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= core_pkg::ARB_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  assign mem_req_o   = own_fetch || own_ls;
  assign mem_we_o    = own_ls && ls_we_i;
  assign mem_addr_o  = own_ls ? ls_addr_i : fetch_addr_i;
  assign mem_wdata_o = own_ls ? ls_wdata_i : '0;

  // ready and data go only to the owner
  assign fetch_ready_o = own_fetch && mem_ready_i;
  assign fetch_rdata_o = own_fetch ? mem_rdata_i : '0;
  assign ls_ready_o    = own_ls && mem_ready_i;
  assign ls_rdata_o    = own_ls ? mem_rdata_i : '0;

  assign ls_busy_o = own_ls || ls_req_i;  // owning or waiting

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic            clk,
  input  logic            reset_i,
  // external memory port
  output logic            mem_req_o,
  output logic            mem_we_o,
  output core_pkg::addr_t mem_addr_o,
  output core_pkg::word_t mem_wdata_o,
  input  logic            mem_ready_i,
  input  core_pkg::word_t mem_rdata_i,
  // load/store stage
  input  logic            ls_req_i,
  input  logic            ls_we_i,
  input  core_pkg::addr_t ls_addr_i,
  input  core_pkg::word_t ls_wdata_i,
  output logic            ls_ready_o,
  output core_pkg::word_t ls_rdata_o,
  // execute stage
  input  logic            ex_branch_valid_i,
  input  logic            ex_branch_taken_i,
  input  core_pkg::addr_t ex_pc_i,
  input  core_pkg::addr_t ex_target_i,
  input  logic            ex_redirect_i,
  input  core_pkg::addr_t ex_redirect_pc_i,
  // decode stage
  input  logic            id_stall_i,
  output logic            inst_valid_o,
  output core_pkg::addr_t inst_addr_o,
  output core_pkg::word_t inst_data_o,
  output core_pkg::trap_t trap_o,
  output logic            pred_taken_o,
  output logic            if_stall_o
);

  core_pkg::addr_t pc;
  logic            pred_taken;
  core_pkg::addr_t pred_target;
  logic            advance;
  logic            fetch_req;
  core_pkg::addr_t fetch_addr;
  logic            fetch_ready;
  core_pkg::word_t fetch_rdata;
  logic            ls_busy;

  pc_reg u_pc_reg (
    .clk              (clk),
    .reset_i          (reset_i),
    .advance_i        (advance),
    .ex_redirect_i    (ex_redirect_i),
    .ex_redirect_pc_i (ex_redirect_pc_i),
    .pred_taken_i     (pred_taken),
    .pred_target_i    (pred_target),
    .pc_o             (pc)
  );

  bpu u_bpu (
    .clk               (clk),
    .reset_i           (reset_i),
    .if_pc_i           (pc),
    .ex_branch_valid_i (ex_branch_valid_i),
    .ex_branch_taken_i (ex_branch_taken_i),
    .ex_pc_i           (ex_pc_i),
    .ex_target_i       (ex_target_i),
    .pred_taken_o      (pred_taken),
    .pred_target_o     (pred_target)
  );

  ifu u_ifu (
    .clk           (clk),
    .reset_i       (reset_i),
    .pc_i          (pc),
    .pred_taken_i  (pred_taken),
    .fetch_ready_i (fetch_ready),
    .fetch_rdata_i (fetch_rdata),
    .fetch_req_o   (fetch_req),
    .fetch_addr_o  (fetch_addr),
    .ls_busy_i     (ls_busy),
    .ex_redirect_i (ex_redirect_i),
    .id_stall_i    (id_stall_i),
    .advance_o     (advance),
    .if_stall_o    (if_stall_o),
    .inst_valid_o  (inst_valid_o),
    .inst_addr_o   (inst_addr_o),
    .inst_data_o   (inst_data_o),
    .trap_o        (trap_o),
    .pred_taken_o  (pred_taken_o)
  );

  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .reset_i       (reset_i),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .fetch_ready_o (fetch_ready),
    .fetch_rdata_o (fetch_rdata),
    .ls_req_i      (ls_req_i),
    .ls_we_i       (ls_we_i),
    .ls_addr_i     (ls_addr_i),
    .ls_wdata_i    (ls_wdata_i),
    .ls_ready_o    (ls_ready_o),
    .ls_rdata_o    (ls_rdata_o),
    .ls_busy_o     (ls_busy),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_ready_i   (mem_ready_i),
    .mem_rdata_i   (mem_rdata_i)
  );

endmodule

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

  localparam core_pkg::word_t FILL       = 32'h5A3C_96E1;  // memory word is address xor this
  localparam int              WAIT_LIMIT = 400;
  localparam core_pkg::addr_t BR_PC      = 32'h0000_0300;
  localparam core_pkg::addr_t BR_TARGET  = 32'h0000_0500;

  logic            clk = 1'b0;
  logic            reset_i;
  logic            mem_req_o;
  logic            mem_we_o;
  core_pkg::addr_t mem_addr_o;
  core_pkg::word_t mem_wdata_o;
  logic            mem_ready_i = 1'b0;
  core_pkg::word_t mem_rdata_i = '0;
  logic            ls_req_i;
  logic            ls_we_i;
  core_pkg::addr_t ls_addr_i;
  core_pkg::word_t ls_wdata_i;
  logic            ls_ready_o;
  core_pkg::word_t ls_rdata_o;
  logic            ex_branch_valid_i;
  logic            ex_branch_taken_i;
  core_pkg::addr_t ex_pc_i;
  core_pkg::addr_t ex_target_i;
  logic            ex_redirect_i;
  core_pkg::addr_t ex_redirect_pc_i;
  logic            id_stall_i;
  logic            inst_valid_o;
  core_pkg::addr_t inst_addr_o;
  core_pkg::word_t inst_data_o;
  core_pkg::trap_t trap_o;
  logic            pred_taken_o;
  logic            if_stall_o;

  core_pkg::word_t    mem [1024];  // 4 KiB behind the port
  int                 mem_wait;
  integer             seed;
  core_pkg::bpu_ctr_t m_ctr    [core_pkg::BPU_ENTRIES];
  logic               m_valid  [core_pkg::BPU_ENTRIES];
  logic [core_pkg::BPU_TAG_W-1:0] m_tag [core_pkg::BPU_ENTRIES];
  core_pkg::addr_t    m_target [core_pkg::BPU_ENTRIES];

  string           test_name;
  core_pkg::addr_t exp_addr;
  core_pkg::word_t exp_data;
  core_pkg::trap_t exp_trap;
  logic            exp_pred;
  core_pkg::word_t exp_ls_rdata;
  logic            consume_q;    // delivery at the coming posedge
  logic            redir_q;
  core_pkg::addr_t redir_pc_q;
  logic            just_reset;
  logic            stall_rand;
  logic            ls_done_q;
  int              deliveries;
  logic            do_redir;
  core_pkg::addr_t redir_target;
  logic            do_train;
  logic            train_taken;
  core_pkg::addr_t train_pc;
  core_pkg::addr_t train_target;

  fetch_top DUT (.*);

  always #20 clk = ~clk;

  // memory with 1 to 4 cycles of latency
  always @(negedge clk) begin
    mem_ready_i = 1'b0;
    if (!reset_i && mem_req_o) begin
      if (mem_wait == 0) begin
        mem_wait = 1 + ($random(seed) & 3);
      end
      mem_wait = mem_wait - 1;
      if (mem_wait == 0) begin
        mem_ready_i = 1'b1;
        if (mem_we_o) begin
          mem[mem_addr_o[11:2]] = mem_wdata_o;
        end else begin
          mem_rdata_i = mem[mem_addr_o[11:2]];
        end
      end
    end
  end

  always @(posedge clk) begin
    if (reset_i) begin
      ls_done_q <= 1'b0;
    end else begin
      ls_done_q <= ls_ready_o;
    end
  end

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic wrong_value(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
    fail_now($sformatf("mismatch %s %s expected %h actual %h", test_name, what, exp_v, act_v));
  endtask

  // taken only on a btb tag hit with the counter upper bit set
  function automatic logic predicts(input core_pkg::addr_t a);
    logic [core_pkg::BPU_IDX_W-1:0] idx;
    idx = a[2 +: core_pkg::BPU_IDX_W];
    return m_valid[idx] && (m_tag[idx] == a[core_pkg::XLEN-1 -: core_pkg::BPU_TAG_W])
           && m_ctr[idx][1];
  endfunction

  function automatic core_pkg::addr_t next_addr(input core_pkg::addr_t a);
    if (predicts(a)) begin
      return m_target[a[2 +: core_pkg::BPU_IDX_W]];
    end
    return a + 32'd4;
  endfunction

  task automatic train_model(input core_pkg::addr_t pc, input logic taken,
                             input core_pkg::addr_t target);
    logic [core_pkg::BPU_IDX_W-1:0] idx;
    idx = pc[2 +: core_pkg::BPU_IDX_W];
    if (taken) begin
      if (m_ctr[idx] != 2'b11) m_ctr[idx] = m_ctr[idx] + 2'b01;
      m_valid[idx]  = 1'b1;
      m_tag[idx]    = pc[core_pkg::XLEN-1 -: core_pkg::BPU_TAG_W];
      m_target[idx] = target;
    end else if (m_ctr[idx] != 2'b00) begin
      m_ctr[idx] = m_ctr[idx] - 2'b01;
    end
  endtask

  task automatic set_expect();
    exp_trap = '0;
    exp_trap[core_pkg::TRAP_INST_ADDR_MISALIGNED] = |exp_addr[1:0];
    exp_trap[core_pkg::TRAP_INST_ACCESS_FAULT]    = (exp_addr >= core_pkg::MEM_BYTES);
    exp_data = (|exp_trap) ? core_pkg::NOP_INST : (exp_addr ^ FILL);
    exp_pred = predicts(exp_addr);
  endtask

  // drives for the current falling edge
  task automatic drive();
    ex_redirect_i     = do_redir;
    ex_redirect_pc_i  = redir_target;
    ex_branch_valid_i = do_train;
    ex_branch_taken_i = train_taken;
    ex_pc_i           = train_pc;
    ex_target_i       = train_target;
    if (do_train) train_model(train_pc, train_taken, train_target);
    if (do_redir || !stall_rand) begin
      id_stall_i = 1'b0;  // buffer drains on a redirect
    end else begin
      id_stall_i = (($random(seed) & 3) == 0);
    end
    consume_q  = inst_valid_o && !id_stall_i;
    redir_q    = do_redir;
    redir_pc_q = redir_target;
    do_redir   = 1'b0;
    do_train   = 1'b0;
  endtask

  task automatic tick();
    @(negedge clk);
    just_reset = 1'b0;
    if (consume_q) deliveries++;
    if (redir_q) begin
      exp_addr = redir_pc_q;
    end else if (consume_q) begin
      exp_addr = next_addr(exp_addr);
    end
    set_expect();
    drive();
  endtask

  // execute-stage event on the current falling edge
  task automatic ex_event(input logic train, input logic taken, input core_pkg::addr_t bpc,
                          input logic redir, input core_pkg::addr_t rpc);
    do_train     = train;
    train_taken  = taken;
    train_pc     = bpc;
    train_target = BR_TARGET;
    do_redir     = redir;
    redir_target = rpc;
    drive();
  endtask

  task automatic wait_deliveries(input int n);
    int target;
    int waited;
    target = deliveries + n;
    waited = 0;
    while (deliveries < target) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) fail_now($sformatf("timeout in %s waiting for fetches", test_name));
    end
  endtask

  task automatic wait_fetch_in_flight();
    int waited;
    waited = 0;
    while (!(mem_req_o && !ls_req_i)) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) fail_now("timeout waiting for a fetch on the memory port");
    end
  endtask

  task automatic ls_access(input logic we, input core_pkg::addr_t addr,
                           input core_pkg::word_t wdata, input core_pkg::word_t exp_rd);
    int waited;
    ls_req_i     = 1'b1;
    ls_we_i      = we;
    ls_addr_i    = addr;
    ls_wdata_i   = wdata;
    exp_ls_rdata = exp_rd;
    waited       = 0;
    tick();
    while (!ls_done_q) begin
      tick();
      waited++;
      if (waited > WAIT_LIMIT) fail_now("timeout waiting for a load/store access to finish");
    end
    ls_req_i = 1'b0;
  endtask

  a_reset: assert property (@(posedge clk) !just_reset ||
      (!mem_req_o && !inst_valid_o && !ls_ready_o && !pred_taken_o && !if_stall_o))
    else fail_now("outputs not idle in the first cycle after reset");
  a_addr: assert property (@(posedge clk) disable iff (reset_i)
      !(inst_valid_o && !id_stall_i) || inst_addr_o == exp_addr)
    else wrong_value("inst_addr_o", exp_addr, $sampled(inst_addr_o));
  a_data: assert property (@(posedge clk) disable iff (reset_i)
      !(inst_valid_o && !id_stall_i) || inst_data_o == exp_data)
    else wrong_value("inst_data_o", exp_data, $sampled(inst_data_o));
  a_trap: assert property (@(posedge clk) disable iff (reset_i)
      !(inst_valid_o && !id_stall_i) || trap_o == exp_trap)
    else wrong_value("trap_o", 32'(exp_trap), 32'($sampled(trap_o)));
  a_pred: assert property (@(posedge clk) disable iff (reset_i)
      !(inst_valid_o && !id_stall_i) || pred_taken_o == exp_pred)
    else wrong_value("pred_taken_o", 32'(exp_pred), 32'($sampled(pred_taken_o)));
  a_ls_rdata: assert property (@(posedge clk) disable iff (reset_i)
      !(ls_ready_o && !ls_we_i) || ls_rdata_o == exp_ls_rdata)
    else wrong_value("ls_rdata_o", exp_ls_rdata, $sampled(ls_rdata_o));
  a_stall_mask: assert property (@(posedge clk) disable iff (reset_i) !(if_stall_o && ls_req_i))
    else fail_now("if_stall_o high while a load/store request waits or owns the port");
  // with no load/store request the port can only be owned by a fetch
  a_stall_fetch: assert property (@(posedge clk) disable iff (reset_i)
      !(mem_req_o && !mem_ready_i && !ls_req_i) || if_stall_o)
    else fail_now("if_stall_o low while a fetch waits on the memory port");
  a_mem_addr: assert property (@(posedge clk) disable iff (reset_i)
      !mem_req_o || (mem_addr_o[1:0] == 2'b00 && mem_addr_o < core_pkg::MEM_BYTES))
    else fail_now("memory request issued for a misaligned or out of range address");

  initial begin
    seed = 12967;
    reset_i = 1'b1;
    id_stall_i = 1'b0;
    ls_req_i = 1'b0;
    ls_we_i = 1'b0;
    ls_addr_i = '0;
    ls_wdata_i = '0;
    ex_branch_valid_i = 1'b0;
    ex_branch_taken_i = 1'b0;
    ex_pc_i = '0;
    ex_target_i = '0;
    ex_redirect_i = 1'b0;
    ex_redirect_pc_i = '0;
    mem_wait = 0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = core_pkg::word_t'(i * 4) ^ FILL;
    end
    for (int i = 0; i < core_pkg::BPU_ENTRIES; i++) begin
      m_ctr[i]   = core_pkg::CTR_INIT;
      m_valid[i] = 1'b0;
    end
    {consume_q, redir_q, do_redir, do_train, just_reset, stall_rand} = '0;
    redir_pc_q = '0;
    redir_target = '0;
    train_taken = 1'b0;
    train_pc = '0;
    train_target = '0;
    exp_ls_rdata = '0;
    deliveries = 0;
    exp_addr = core_pkg::RESET_PC;
    set_expect();
    test_name = "reset";
    repeat (10) @(negedge clk);
    reset_i = 1'b0;
    just_reset = 1'b1;

    test_name = "sequential";
    stall_rand = 1'b1;
    wait_deliveries(40);

    test_name = "load_store";
    ls_access(1'b0, 32'h0000_0C00, '0, 32'h0000_0C00 ^ FILL);
    ls_access(1'b1, 32'h0000_0C04, 32'hCAFE_F00D, '0);
    ls_access(1'b0, 32'h0000_0C04, '0, 32'hCAFE_F00D);  // store must be visible
    ls_access(1'b0, 32'h0000_0C40, '0, 32'h0000_0C40 ^ FILL);
    wait_deliveries(8);

    test_name = "redirect";
    wait_fetch_in_flight();
    ex_event(1'b0, 1'b0, '0, 1'b1, 32'h0000_0200);
    wait_deliveries(6);

    test_name = "predict";
    ex_event(1'b1, 1'b1, BR_PC, 1'b1, BR_PC);  // counter 01 to 10
    wait_deliveries(6);
    ex_event(1'b1, 1'b0, BR_PC, 1'b0, '0);
    tick();
    ex_event(1'b1, 1'b0, BR_PC, 1'b1, BR_PC);
    wait_deliveries(4);

    test_name = "trap_misaligned";
    ex_event(1'b0, 1'b0, '0, 1'b1, 32'h0000_0102);
    wait_deliveries(3);
    test_name = "trap_access_fault";
    ex_event(1'b0, 1'b0, '0, 1'b1, core_pkg::MEM_BYTES);
    wait_deliveries(3);
    test_name = "recover";
    ex_event(1'b0, 1'b0, '0, 1'b1, 32'h0000_0040);
    wait_deliveries(4);

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* all.f */
core_pkg.sv
pc_reg.sv
bpu.sv
ifu.sv
mem_arbiter.sv
fetch_top.sv
tb_fetch_top.sv

/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLAGS     ?= --binary --assert
FILELIST  ?= all.f
SIM       ?= obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fails unless the testbench passes"
	@echo "  clean  remove the obj_dir build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLAGS FILELIST"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
